// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - include_dirs:
      - include
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_if.sv
      - rtl/fetch_pc_gen.sv
      - rtl/fetch_assoc_cache.sv
      - rtl/fetch_lookup.sv
      - rtl/fetch_queue.sv
      - rtl/fetch_unit_top.sv
  - target: test
    files:
      - tb/fetch_unit_assertions.sv
      - tb/fetch_unit_tb.sv

// ==== include/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Byte address and instruction widths
`define FETCH_ADDR_W 32
`define FETCH_WORD_W 32

// Fully associative fetch cache entries
`define FETCH_CACHE_DEPTH 8

// Queue pointer width
// One slot stays unused to tell full from empty
`define FETCH_QUEUE_AW 3

`endif

// ==== project.f ====
+incdir+include
rtl/fetch_pkg.sv
rtl/fetch_if.sv
rtl/fetch_pc_gen.sv
rtl/fetch_assoc_cache.sv
rtl/fetch_lookup.sv
rtl/fetch_queue.sv
rtl/fetch_unit_top.sv
tb/fetch_unit_assertions.sv
tb/fetch_unit_tb.sv

// ==== rtl/fetch_assoc_cache.sv ====
`include "fetch_defines.svh"

module fetch_assoc_cache import fetch_pkg::*; #(
    parameter int DEPTH = `FETCH_CACHE_DEPTH
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_push,
    input  fetch_addr_t i_push_key,
    input  fetch_word_t i_push_data,
    input  fetch_addr_t i_find_key,
    output logic        o_found,
    output fetch_word_t o_found_data
);

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    fetch_addr_t         key_q  [DEPTH];
    fetch_word_t         data_q [DEPTH];
    logic    [DEPTH-1:0] valid_q;
    logic    [IW-1:0]    victim_q;

    logic                push_hit;
    logic    [IW-1:0]    hit_idx;
    logic                has_free;
    logic    [IW-1:0]    free_idx;
    logic    [IW-1:0]    wr_idx;

    always_comb begin
        o_found      = 1'b0;
        o_found_data = '0;
        push_hit     = 1'b0;
        hit_idx      = '0;
        has_free     = 1'b0;
        free_idx     = '0;
        // Walk downwards so the lowest free slot is the one left standing
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i] && key_q[i] == i_find_key) begin
                o_found      = 1'b1;
                o_found_data = data_q[i];
            end
            if (valid_q[i] && key_q[i] == i_push_key) begin
                push_hit = 1'b1;
                hit_idx  = IW'(i);
            end
            if (!valid_q[i]) begin
                has_free = 1'b1;
                free_idx = IW'(i);
            end
        end
    end

    assign wr_idx = push_hit ? hit_idx : (has_free ? free_idx : victim_q);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (i_push) begin
            valid_q[wr_idx] <= 1'b1;
            // Round-robin only moves when an older entry is evicted
            if (!push_hit && !has_free) begin
                victim_q <= (victim_q == IW'(DEPTH - 1)) ? '0 : victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            key_q[wr_idx]  <= i_push_key;
            data_q[wr_idx] <= i_push_data;
        end
    end

endmodule

// ==== rtl/fetch_if.sv ====
interface fetch_req_if import fetch_pkg::*; ();

    logic        valid;
    logic        ready;
    fetch_addr_t addr;
    // One-cycle redirect pulse that both stages see together
    logic        flush;

    modport src (
        output valid,
        output addr,
        output flush,
        input  ready
    );

    modport dst (
        input  valid,
        input  addr,
        input  flush,
        output ready
    );

endinterface

// ==== rtl/fetch_lookup.sv ====
`include "fetch_defines.svh"

module fetch_lookup import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    fetch_req_if.dst     req,
    output logic         o_push,
    output fetch_entry_t o_entry,
    input  logic         i_full,
    output fetch_addr_t  o_araddr,
    output logic [2:0]   o_arprot,
    output logic         o_arvalid,
    input  logic         i_arready,
    input  fetch_word_t  i_rdata,
    input  logic [1:0]   i_rresp,
    input  logic         i_rvalid,
    output logic         o_rready
);

    localparam logic [1:0] RESP_OKAY = 2'b00;
    // Unprivileged, secure, instruction access
    localparam logic [2:0] PROT_INSTR = 3'b100;

    lookup_state_t state_q;
    logic          drop_q;
    fetch_addr_t   addr_q;
    fetch_word_t   word_q;
    logic          fault_q;

    logic          accept;
    logic          hit;
    fetch_word_t   hit_data;
    logic          r_done;
    logic          r_ok;

    assign accept = req.valid && req.ready;
    assign r_done = o_rready && i_rvalid;
    assign r_ok   = (i_rresp == RESP_OKAY);

    fetch_assoc_cache #(
        .DEPTH (`FETCH_CACHE_DEPTH)
    ) u_cache (
        .clk          (clk),
        .rstn         (rstn),
        .i_push       (r_done && r_ok),
        .i_push_key   (addr_q),
        .i_push_data  (i_rdata),
        .i_find_key   (req.addr),
        .o_found      (hit),
        .o_found_data (hit_data)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= LK_IDLE;
            drop_q  <= 1'b0;
        end else begin
            case (state_q)
                LK_IDLE: begin
                    if (accept) begin
                        state_q <= hit ? LK_OUT : LK_AR;
                    end
                end
                LK_AR: begin
                    if (i_arready) begin
                        state_q <= LK_R;
                    end
                end
                LK_R: begin
                    if (i_rvalid) begin
                        state_q <= (drop_q || req.flush) ? LK_IDLE : LK_OUT;
                    end
                end
                LK_OUT: begin
                    if (req.flush || !i_full) begin
                        state_q <= LK_IDLE;
                    end
                end
                default: state_q <= LK_IDLE;
            endcase
            // Item is stale once a flush lands during the bus transaction
            drop_q <= (state_q == LK_AR || state_q == LK_R) && (drop_q || req.flush);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req.addr;
            word_q  <= hit_data;
            fault_q <= 1'b0;
        end else if (r_done) begin
            word_q  <= i_rdata;
            fault_q <= !r_ok;
        end
    end

    assign req.ready = (state_q == LK_IDLE);
    assign o_arvalid = (state_q == LK_AR);
    assign o_rready  = (state_q == LK_R);
    assign o_araddr  = addr_q;
    assign o_arprot  = PROT_INSTR;
    assign o_push    = (state_q == LK_OUT) && !i_full && !req.flush;
    assign o_entry   = {addr_q, word_q, fault_q};

endmodule

// ==== rtl/fetch_pc_gen.sv ====
module fetch_pc_gen import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_redirect,
    input  fetch_addr_t i_redirect_addr,
    fetch_req_if.src    req
);

    fetch_addr_t pc_q;
    logic        valid_q;
    logic        flush_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q    <= '0;
            valid_q <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            flush_q <= i_redirect;
            // Request goes quiet for the cycle in which flush clears the pipe
            valid_q <= !i_redirect;
            if (i_redirect) begin
                pc_q <= i_redirect_addr & ~fetch_addr_t'(3);
            end else if (req.valid && req.ready) begin
                pc_q <= pc_q + fetch_addr_t'(4);
            end
        end
    end

    assign req.valid = valid_q;
    assign req.addr  = pc_q;
    assign req.flush = flush_q;

endmodule

// ==== rtl/fetch_pkg.sv ====
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] fetch_addr_t;
    typedef logic [`FETCH_WORD_W-1:0] fetch_word_t;

    // Packed as {address, word, fault}
    typedef logic [`FETCH_ADDR_W+`FETCH_WORD_W:0] fetch_entry_t;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_AR,
        LK_R,
        LK_OUT
    } lookup_state_t;

endpackage

// ==== rtl/fetch_queue.sv ====
`include "fetch_defines.svh"

module fetch_queue import fetch_pkg::*; #(
    parameter int AW = `FETCH_QUEUE_AW
) (
    input  logic         clk,
    input  logic         rstn,
    input  logic         i_flush,
    input  logic         i_push,
    input  fetch_entry_t i_entry,
    output logic         o_full,
    output logic         o_valid,
    output fetch_entry_t o_entry,
    input  logic         i_ready
);

    fetch_entry_t    mem [2**AW];
    logic   [AW-1:0] wr_ptr;
    logic   [AW-1:0] rd_ptr;
    logic            empty;
    logic            push;
    logic            pop;

    assign empty  = (wr_ptr == rd_ptr);
    assign o_full = (wr_ptr + 1'b1 == rd_ptr);
    assign push   = i_push && !o_full;
    // Words queued before a redirect are never offered again
    assign o_valid = !empty && !i_flush;
    assign pop     = o_valid && i_ready;
    assign o_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_entry;
        end
    end

endmodule

// ==== rtl/fetch_unit_top.sv ====
`include "fetch_defines.svh"

module fetch_unit_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_redirect,
    input  fetch_addr_t i_redirect_addr,
    output logic        o_instr_valid,
    output fetch_word_t o_instr,
    output fetch_addr_t o_instr_addr,
    output logic        o_instr_fault,
    input  logic        i_instr_ready,
    output fetch_addr_t o_araddr,
    output logic [2:0]  o_arprot,
    output logic        o_arvalid,
    input  logic        i_arready,
    input  fetch_word_t i_rdata,
    input  logic [1:0]  i_rresp,
    input  logic        i_rvalid,
    output logic        o_rready
);

    fetch_req_if  req_if ();

    logic         push;
    fetch_entry_t push_entry;
    logic         q_full;
    fetch_entry_t q_entry;

    fetch_pc_gen u_pc_gen (
        .clk             (clk),
        .rstn            (rstn),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .req             (req_if.src)
    );

    fetch_lookup u_lookup (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req_if.dst),
        .o_push    (push),
        .o_entry   (push_entry),
        .i_full    (q_full),
        .o_araddr  (o_araddr),
        .o_arprot  (o_arprot),
        .o_arvalid (o_arvalid),
        .i_arready (i_arready),
        .i_rdata   (i_rdata),
        .i_rresp   (i_rresp),
        .i_rvalid  (i_rvalid),
        .o_rready  (o_rready)
    );

    fetch_queue #(
        .AW (`FETCH_QUEUE_AW)
    ) u_queue (
        .clk     (clk),
        .rstn    (rstn),
        .i_flush (req_if.flush),
        .i_push  (push),
        .i_entry (push_entry),
        .o_full  (q_full),
        .o_valid (o_instr_valid),
        .o_entry (q_entry),
        .i_ready (i_instr_ready)
    );

    assign {o_instr_addr, o_instr, o_instr_fault} = q_entry;

endmodule

// ==== tb/fetch_unit_assertions.sv ====
module fetch_unit_assertions import fetch_pkg::*; (
    input logic        clk,
    input logic        rstn,
    input logic        i_redirect,
    input logic        o_instr_valid,
    input fetch_word_t o_instr,
    input fetch_addr_t o_instr_addr,
    input logic        o_instr_fault,
    input logic        i_instr_ready,
    input fetch_addr_t o_araddr,
    input logic [2:0]  o_arprot,
    input logic        o_arvalid,
    input logic        i_arready,
    input logic        i_rvalid,
    input logic        o_rready
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // Quiet from the first reset edge until the pipeline starts
    reset_quiet: assert property (@(posedge clk)
        !rstn |=> !o_instr_valid && !o_arvalid && !o_rready)
    else begin
        $error("decode or bus handshake active during reset");
        fail_count++;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
    else begin
        $error("ARVALID dropped or ARADDR changed before ARREADY");
        fail_count++;
    end

    // Every fetch read is an unprivileged secure instruction access
    ar_prot: assert property (@(posedge clk) disable iff (!rstn)
        o_arvalid |-> o_arprot == 3'b100)
    else begin
        $error("ARPROT does not mark an instruction access");
        fail_count++;
    end

    r_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_rready && !i_rvalid |=> o_rready)
    else begin
        $error("RREADY dropped before RVALID");
        fail_count++;
    end

    // A redirect may withdraw the head word, a stall alone may not
    decode_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_instr_valid && !i_instr_ready && !i_redirect |=>
        o_instr_valid && $stable(o_instr) && $stable(o_instr_addr) && $stable(o_instr_fault))
    else begin
        $error("decode outputs changed while stalled");
        fail_count++;
    end

endmodule

bind fetch_unit_top fetch_unit_assertions u_assertions (.*);

// ==== tb/fetch_unit_tb.sv ====
module fetch_unit_tb import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD  = 100;
    localparam fetch_word_t DATA_KEY    = 32'hA5A5_5A5A;
    localparam int          CACHE_SLOTS = 8;
    localparam int          TOTAL_WORDS = 60;
    // Two bus delays of up to 3 cycles, pipeline latency and decoder stalls
    localparam int          WORD_CYCLES = 40;
    localparam int          LIMIT_CYCLES = 16 + TOTAL_WORDS * WORD_CYCLES;

    logic        clk = 1'b0;
    logic        rstn;
    logic        i_redirect;
    fetch_addr_t i_redirect_addr;
    logic        o_instr_valid;
    fetch_word_t o_instr;
    fetch_addr_t o_instr_addr;
    logic        o_instr_fault;
    logic        i_instr_ready;
    fetch_addr_t o_araddr;
    logic [2:0]  o_arprot;
    logic        o_arvalid;
    logic        i_arready;
    fetch_word_t i_rdata;
    logic [1:0]  i_rresp;
    logic        i_rvalid;
    logic        o_rready;

    integer      seed = 32'h9055fae4;
    int          errors = 0;
    int          delivered = 0;
    int          fault_ars = 0;
    fetch_addr_t recent_fill = '0;
    logic        ar_seen;
    int          ar_delay;
    logic        r_pending;
    int          r_delay;
    fetch_addr_t r_addr;
    fetch_addr_t expect_addr = '0;
    logic        first_ar = 1'b1;
    // Cache model holding the last distinct good fills with the oldest in front
    fetch_addr_t fill_fifo [$];

    fetch_unit_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic in_fault_window(fetch_addr_t addr);
        return addr >= 32'h100 && addr <= 32'h10C;
    endfunction

    function automatic logic cache_holds(fetch_addr_t addr);
        foreach (fill_fifo[i]) begin
            if (fill_fifo[i] == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic wait_words(input int count);
        int target;
        target = delivered + count;
        while (delivered < target) begin
            @(posedge clk);
        end
    endtask

    task automatic redirect_to(input fetch_addr_t addr);
        @(posedge clk);
        i_redirect      <= 1'b1;
        i_redirect_addr <= addr;
        @(posedge clk);
        i_redirect      <= 1'b0;
    endtask

    task automatic print_counts();
        $display("errors: %0d scoreboard, %0d assertion", errors, i_dut.u_assertions.fail_count);
    endtask

    // Memory slave and decoder share one random stream
    always @(posedge clk) begin
        if (!rstn) begin
            i_arready     <= 1'b0;
            i_rvalid      <= 1'b0;
            i_instr_ready <= 1'b0;
            ar_seen   = 1'b0;
            r_pending = 1'b0;
        end else begin
            i_instr_ready <= ({$random(seed)} % 4) != 0;
            if (o_arvalid && i_arready) begin
                i_arready <= 1'b0;
                ar_seen   = 1'b0;
                r_pending = 1'b1;
                r_addr    = o_araddr;
                r_delay   = {$random(seed)} % 4;
            end else if (o_arvalid) begin
                if (!ar_seen) begin
                    ar_seen  = 1'b1;
                    ar_delay = {$random(seed)} % 4;
                end
                if (ar_delay == 0) begin
                    i_arready <= 1'b1;
                end else begin
                    ar_delay--;
                end
            end
            if (o_rready && i_rvalid) begin
                i_rvalid  <= 1'b0;
                r_pending = 1'b0;
            end else if (r_pending) begin
                if (r_delay == 0) begin
                    i_rvalid <= 1'b1;
                    i_rdata  <= r_addr ^ DATA_KEY;
                    i_rresp  <= in_fault_window(r_addr) ? 2'b10 : 2'b00;
                end else begin
                    r_delay--;
                end
            end
        end
    end

    // Scoreboard for decoded words and bus reads
    always @(posedge clk) begin
        if (rstn) begin
            if (o_instr_valid && i_instr_ready) begin
                assert (o_instr_addr == expect_addr) else begin
                    $display("mismatch at %0t: address %h, expected %h",
                             $time, o_instr_addr, expect_addr);
                    errors++;
                end
                assert (o_instr == (expect_addr ^ DATA_KEY)) else begin
                    $display("mismatch at %0t: word %h, expected %h",
                             $time, o_instr, expect_addr ^ DATA_KEY);
                    errors++;
                end
                assert (o_instr_fault == in_fault_window(expect_addr)) else begin
                    $display("mismatch at %0t: fault %b at address %h",
                             $time, o_instr_fault, expect_addr);
                    errors++;
                end
                expect_addr = expect_addr + 32'd4;
                delivered <= delivered + 1;
            end
            // Words handed over up to the edge that sees the redirect are still old ones
            if (i_redirect) begin
                expect_addr = i_redirect_addr & ~32'h3;
            end
            if (o_arvalid && i_arready) begin
                if (first_ar) begin
                    assert (o_araddr == '0) else begin
                        $display("mismatch at %0t: first read address %h", $time, o_araddr);
                        errors++;
                    end
                    first_ar = 1'b0;
                end
                assert (!cache_holds(o_araddr)) else begin
                    $display("at %0t the memory was read for %h although the cache holds it",
                             $time, o_araddr);
                    errors++;
                end
                if (in_fault_window(o_araddr)) begin
                    fault_ars <= fault_ars + 1;
                end
            end
            if (o_rready && i_rvalid && i_rresp == 2'b00 && !cache_holds(o_araddr)) begin
                fill_fifo.push_back(o_araddr);
                if (fill_fifo.size() > CACHE_SLOTS) begin
                    void'(fill_fifo.pop_front());
                end
                recent_fill <= o_araddr;
            end
        end
    end

    initial begin
        rstn            = 1'b0;
        i_redirect      = 1'b0;
        i_redirect_addr = '0;
        i_instr_ready   = 1'b0;
        i_arready       = 1'b0;
        i_rdata         = '0;
        i_rresp         = 2'b00;
        i_rvalid        = 1'b0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        wait_words(24);
        redirect_to(32'h200);
        wait_words(12);
        // Back a few words into what was just filled
        redirect_to(recent_fill - 32'd12);
        wait_words(8);
        redirect_to(32'hF8);
        wait_words(10);
        redirect_to(32'h100);
        wait_words(6);
        assert (fault_ars >= 8) else begin
            $display("faulting addresses were read only %0d times, not again on the revisit",
                     fault_ars);
            errors++;
        end
        repeat (4) @(posedge clk);
        print_counts();
        if (errors == 0 && i_dut.u_assertions.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout: only %0d of %0d words arrived in time", delivered, TOTAL_WORDS);
        print_counts();
        $display("Finished with errors");
        $finish;
    end

endmodule
